// File: noc_pkg.sv
package noc_pkg;

  localparam int flit_data_w = 32;
  localparam int coord_w     = 3;

  // Header layout inside the head flit data.
  localparam int type_lsb      = 0;
  localparam int type_w        = 3;
  localparam int dst_x_lsb     = 3;
  localparam int dst_y_lsb     = 6;
  localparam int src_x_lsb     = 9;
  localparam int src_y_lsb     = 12;
  localparam int tag_lsb       = 15;
  localparam int tag_w         = 4;
  localparam int burst_len_lsb = 19;
  localparam int burst_len_w   = 4;
  localparam int invalid_lsb   = 23;
  localparam int status_lsb    = 24;
  localparam int status_w      = 2;

  typedef enum logic [type_w-1:0] {
    READ               = 3'd0,
    WRITE              = 3'd1,
    POSTED_WRITE       = 3'd2,
    RESPONSE           = 3'd3,
    RESPONSE_WITH_DATA = 3'd4
  } packet_type_e;

  typedef enum logic [status_w-1:0] {
    OKAY         = 2'b00,
    DECODE_ERROR = 2'b11
  } status_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ABSORB,
    ST_SEND_HEADER,
    ST_SEND_DATA
  } responder_state_e;

endpackage

// File: noc_route_demux.sv
module noc_route_demux
  import noc_pkg::*;
#(
  parameter int SIZE_X = 4,
  parameter int SIZE_Y = 4
)(
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_flit_valid,
  input  logic                   i_flit_head,
  input  logic                   i_flit_tail,
  input  logic [flit_data_w-1:0] i_flit_data,
  input  logic                   i_normal_ready,
  input  logic                   i_error_ready,
  input  logic                   i_busy,
  output logic                   o_flit_ready,
  output logic                   o_normal_valid,
  output logic                   o_error_valid,
  output logic                   o_fwd_head,
  output logic                   o_fwd_tail,
  output logic [flit_data_w-1:0] o_fwd_data,
  output logic                   o_sel_error
);

  logic [coord_w-1:0] dst_x;
  logic [coord_w-1:0] dst_y;
  logic               dst_invalid;
  logic               head_error;
  logic               head_blocked;
  logic               new_head;
  logic               route;
  logic               route_q;

  assign dst_x       = i_flit_data[dst_x_lsb +: coord_w];
  assign dst_y       = i_flit_data[dst_y_lsb +: coord_w];
  assign dst_invalid = i_flit_data[invalid_lsb];

  assign head_error = dst_invalid || (dst_x >= SIZE_X) || (dst_y >= SIZE_Y);

  // One packet at a time in the error path.
  assign head_blocked = i_flit_head && i_busy;
  assign new_head     = i_flit_valid && i_flit_head && !i_busy;

  // Fresh decision on a head, otherwise the packet's latched route.
  assign route = new_head ? head_error : route_q;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      route_q <= 1'b0;
    end else if (new_head && o_flit_ready) begin
      route_q <= head_error;
    end
  end

  assign o_normal_valid = i_flit_valid && !head_blocked && !route;
  assign o_error_valid  = i_flit_valid && !head_blocked && route;
  assign o_flit_ready   = !head_blocked && (route ? i_error_ready : i_normal_ready);

  assign o_fwd_head  = i_flit_head;
  assign o_fwd_tail  = i_flit_tail;
  assign o_fwd_data  = i_flit_data;
  assign o_sel_error = route; // Also steers the output mux.

endmodule

// File: noc_error_responder.sv
module noc_error_responder
  import noc_pkg::*;
#(
  parameter logic [flit_data_w-1:0] ERROR_DATA = '1
)(
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_flit_valid,
  input  logic                   i_flit_head,
  input  logic                   i_flit_tail,
  input  logic [flit_data_w-1:0] i_flit_data,
  input  logic                   i_resp_ready,
  output logic                   o_flit_ready,
  output logic                   o_busy,
  output logic                   o_resp_valid,
  output logic                   o_resp_head,
  output logic                   o_resp_tail,
  output logic [flit_data_w-1:0] o_resp_data
);

  responder_state_e state;
  responder_state_e state_next;

  packet_type_e           in_type;
  logic                   in_non_posted;
  logic                   req_non_posted;
  packet_type_e           req_type;
  logic [coord_w-1:0]     req_dst_x;
  logic [coord_w-1:0]     req_dst_y;
  logic [coord_w-1:0]     req_src_x;
  logic [coord_w-1:0]     req_src_y;
  logic [tag_w-1:0]       req_tag;
  logic [burst_len_w-1:0] req_len;
  logic [burst_len_w-1:0] beat;
  logic [flit_data_w-1:0] resp_hdr;
  logic                   is_read;
  logic                   flit_take;
  logic                   head_take;
  logic                   resp_take;

  assign in_type        = packet_type_e'(i_flit_data[type_lsb +: type_w]);
  assign in_non_posted  = (in_type == READ) || (in_type == WRITE);
  assign req_non_posted = (req_type == READ) || (req_type == WRITE);
  assign is_read        = (req_type == READ);

  assign o_flit_ready = (state == ST_IDLE) || (state == ST_ABSORB);
  assign o_busy       = (state != ST_IDLE);
  assign flit_take    = i_flit_valid && o_flit_ready;
  assign head_take    = flit_take && (state == ST_IDLE) && i_flit_head;
  assign resp_take    = o_resp_valid && i_resp_ready;

  // Header fields of the diverted request.
  always_ff @(posedge i_clk) begin
    if (head_take) begin
      req_type  <= in_type;
      req_dst_x <= i_flit_data[dst_x_lsb +: coord_w];
      req_dst_y <= i_flit_data[dst_y_lsb +: coord_w];
      req_src_x <= i_flit_data[src_x_lsb +: coord_w];
      req_src_y <= i_flit_data[src_y_lsb +: coord_w];
      req_tag   <= i_flit_data[tag_lsb +: tag_w];
      req_len   <= i_flit_data[burst_len_lsb +: burst_len_w];
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (head_take) begin
          if (!i_flit_tail) begin
            state_next = ST_ABSORB;
          end else if (in_non_posted) begin
            state_next = ST_SEND_HEADER;
          end
        end
      end
      ST_ABSORB: begin
        if (flit_take && i_flit_tail) begin
          state_next = req_non_posted ? ST_SEND_HEADER : ST_IDLE; // Posted writes vanish.
        end
      end
      ST_SEND_HEADER: begin
        if (resp_take) begin
          state_next = o_resp_tail ? ST_IDLE : ST_SEND_DATA;
        end
      end
      ST_SEND_DATA: begin
        if (resp_take && o_resp_tail) begin
          state_next = ST_IDLE;
        end
      end
      default: state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= ST_IDLE;
      beat  <= '0;
    end else begin
      state <= state_next;
      if (state == ST_SEND_HEADER) begin
        beat <= '0;
      end else if (resp_take) begin
        beat <= beat + 1'b1;
      end
    end
  end

  // Response header with source and destination swapped.
  always_comb begin
    resp_hdr = '0;
    resp_hdr[type_lsb +: type_w]           = is_read ? RESPONSE_WITH_DATA : RESPONSE;
    resp_hdr[dst_x_lsb +: coord_w]         = req_src_x;
    resp_hdr[dst_y_lsb +: coord_w]         = req_src_y;
    resp_hdr[src_x_lsb +: coord_w]         = req_dst_x;
    resp_hdr[src_y_lsb +: coord_w]         = req_dst_y;
    resp_hdr[tag_lsb +: tag_w]             = req_tag;
    resp_hdr[burst_len_lsb +: burst_len_w] = is_read ? req_len : '0;
    resp_hdr[status_lsb +: status_w]       = DECODE_ERROR;
  end

  assign o_resp_valid = (state == ST_SEND_HEADER) || (state == ST_SEND_DATA);
  assign o_resp_head  = (state == ST_SEND_HEADER);
  assign o_resp_data  = (state == ST_SEND_DATA) ? ERROR_DATA : resp_hdr;

  always_comb begin
    if (state == ST_SEND_HEADER) begin
      o_resp_tail = !is_read || (req_len == '0);
    end else begin
      o_resp_tail = (beat == req_len - 1'b1); // Last data beat.
    end
  end

endmodule

// File: noc_output_stage.sv
module noc_output_stage
  import noc_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_sel_error,
  input  logic                   i_normal_valid,
  input  logic                   i_normal_head,
  input  logic                   i_normal_tail,
  input  logic [flit_data_w-1:0] i_normal_data,
  input  logic                   i_resp_valid,
  input  logic                   i_resp_head,
  input  logic                   i_resp_tail,
  input  logic [flit_data_w-1:0] i_resp_data,
  input  logic                   i_flit_ready,
  output logic                   o_normal_ready,
  output logic                   o_resp_ready,
  output logic                   o_flit_valid,
  output logic                   o_flit_head,
  output logic                   o_flit_tail,
  output logic [flit_data_w-1:0] o_flit_data
);

  logic                   in_valid;
  logic                   in_head;
  logic                   in_tail;
  logic [flit_data_w-1:0] in_data;
  logic                   in_ready_q;
  logic                   push;
  logic                   pop;
  logic [1:0]             count;
  logic [1:0]             count_next;
  logic                   wr_ptr;
  logic                   rd_ptr;

  // Entry storage, head and tail kept beside the data.
  logic                   buf_head [2];
  logic                   buf_tail [2];
  logic [flit_data_w-1:0] buf_data [2];

  assign in_valid = i_sel_error ? i_resp_valid : i_normal_valid;
  assign in_head  = i_sel_error ? i_resp_head  : i_normal_head;
  assign in_tail  = i_sel_error ? i_resp_tail  : i_normal_tail;
  assign in_data  = i_sel_error ? i_resp_data  : i_normal_data;

  assign o_normal_ready = in_ready_q && !i_sel_error;
  assign o_resp_ready   = in_ready_q && i_sel_error;

  assign push       = in_valid && in_ready_q;
  assign pop        = o_flit_valid && i_flit_ready;
  assign count_next = count + 2'(push) - 2'(pop);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      count      <= '0;
      wr_ptr     <= 1'b0;
      rd_ptr     <= 1'b0;
      in_ready_q <= 1'b1;
    end else begin
      count      <= count_next;
      in_ready_q <= (count_next < 2'd2);
      if (push) wr_ptr <= !wr_ptr;
      if (pop)  rd_ptr <= !rd_ptr;
    end
  end

  always_ff @(posedge i_clk) begin
    if (push) begin
      buf_head[wr_ptr] <= in_head;
      buf_tail[wr_ptr] <= in_tail;
      buf_data[wr_ptr] <= in_data;
    end
  end

  assign o_flit_valid = (count != '0);
  assign o_flit_head  = buf_head[rd_ptr];
  assign o_flit_tail  = buf_tail[rd_ptr];
  assign o_flit_data  = buf_data[rd_ptr];

endmodule

// File: noc_error_checker.sv
module noc_error_checker
  import noc_pkg::*;
#(
  parameter int                     SIZE_X     = 4,
  parameter int                     SIZE_Y     = 4,
  parameter logic [flit_data_w-1:0] ERROR_DATA = '1
)(
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_flit_valid,
  input  logic                   i_flit_head,
  input  logic                   i_flit_tail,
  input  logic [flit_data_w-1:0] i_flit_data,
  output logic                   o_flit_ready,
  output logic                   o_flit_valid,
  output logic                   o_flit_head,
  output logic                   o_flit_tail,
  output logic [flit_data_w-1:0] o_flit_data,
  input  logic                   i_flit_ready
);

  logic                   normal_valid;
  logic                   normal_ready;
  logic                   error_valid;
  logic                   error_ready;
  logic                   fwd_head;
  logic                   fwd_tail;
  logic [flit_data_w-1:0] fwd_data;
  logic                   sel_error;
  logic                   busy;
  logic                   resp_valid;
  logic                   resp_ready;
  logic                   resp_head;
  logic                   resp_tail;
  logic [flit_data_w-1:0] resp_data;

  noc_route_demux #(
    .SIZE_X (SIZE_X),
    .SIZE_Y (SIZE_Y)
  ) u_demux (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_flit_valid   (i_flit_valid),
    .i_flit_head    (i_flit_head),
    .i_flit_tail    (i_flit_tail),
    .i_flit_data    (i_flit_data),
    .i_normal_ready (normal_ready),
    .i_error_ready  (error_ready),
    .i_busy         (busy),
    .o_flit_ready   (o_flit_ready),
    .o_normal_valid (normal_valid),
    .o_error_valid  (error_valid),
    .o_fwd_head     (fwd_head),
    .o_fwd_tail     (fwd_tail),
    .o_fwd_data     (fwd_data),
    .o_sel_error    (sel_error)
  );

  noc_error_responder #(
    .ERROR_DATA (ERROR_DATA)
  ) u_responder (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_flit_valid (error_valid),
    .i_flit_head  (fwd_head),
    .i_flit_tail  (fwd_tail),
    .i_flit_data  (fwd_data),
    .i_resp_ready (resp_ready),
    .o_flit_ready (error_ready),
    .o_busy       (busy),
    .o_resp_valid (resp_valid),
    .o_resp_head  (resp_head),
    .o_resp_tail  (resp_tail),
    .o_resp_data  (resp_data)
  );

  noc_output_stage u_output (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_sel_error    (sel_error),
    .i_normal_valid (normal_valid),
    .i_normal_head  (fwd_head),
    .i_normal_tail  (fwd_tail),
    .i_normal_data  (fwd_data),
    .i_resp_valid   (resp_valid),
    .i_resp_head    (resp_head),
    .i_resp_tail    (resp_tail),
    .i_resp_data    (resp_data),
    .i_flit_ready   (i_flit_ready),
    .o_normal_ready (normal_ready),
    .o_resp_ready   (resp_ready),
    .o_flit_valid   (o_flit_valid),
    .o_flit_head    (o_flit_head),
    .o_flit_tail    (o_flit_tail),
    .o_flit_data    (o_flit_data)
  );

endmodule

// File: noc_error_checker_chk.sv
module noc_error_checker_chk
  import noc_pkg::*;
(
  input logic                   i_clk,
  input logic                   i_rst_n,
  input logic                   i_in_head,
  input logic                   i_in_ready,
  input logic                   i_resp_valid,
  input logic                   i_resp_ready,
  input logic                   i_resp_tail,
  input logic                   i_out_valid,
  input logic                   i_out_ready,
  input logic                   i_out_head,
  input logic                   i_out_tail,
  input logic [flit_data_w-1:0] i_out_data
);

  // A stalled flit stays put.
  out_hold: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (i_out_valid && !i_out_ready) |=> (i_out_valid && $stable(i_out_data) &&
                                       $stable(i_out_head) && $stable(i_out_tail))
  ) else $error("output flit dropped or changed while stalled");

  out_idle_in_reset: assert property (
    @(posedge i_clk) !i_rst_n |-> !i_out_valid
  ) else $error("output valid high during reset");

  // No new head gets in until the whole error response has left.
  head_blocked_during_resp: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (i_resp_valid && !(i_resp_ready && i_resp_tail)) |=> !(i_in_head && i_in_ready)
  ) else $error("head flit accepted while error response pending");

endmodule

bind noc_error_checker noc_error_checker_chk chk_i (
  .i_clk        (i_clk),
  .i_rst_n      (i_rst_n),
  .i_in_head    (i_flit_head),
  .i_in_ready   (o_flit_ready),
  .i_resp_valid (resp_valid),
  .i_resp_ready (resp_ready),
  .i_resp_tail  (resp_tail),
  .i_out_valid  (o_flit_valid),
  .i_out_ready  (i_flit_ready),
  .i_out_head   (o_flit_head),
  .i_out_tail   (o_flit_tail),
  .i_out_data   (o_flit_data)
);

// File: tb_noc_error_checker.sv
module tb_noc_error_checker
  import noc_pkg::*;
();

  localparam int                     SIZE_X     = 4;
  localparam int                     SIZE_Y     = 4;
  localparam logic [flit_data_w-1:0] ERROR_DATA = '1;

  logic                   i_clk;
  logic                   i_rst_n;
  logic                   i_flit_valid;
  logic                   i_flit_head;
  logic                   i_flit_tail;
  logic [flit_data_w-1:0] i_flit_data;
  logic                   i_flit_ready;
  logic                   o_flit_ready;
  logic                   o_flit_valid;
  logic                   o_flit_head;
  logic                   o_flit_tail;
  logic [flit_data_w-1:0] o_flit_data;

  // Packet table.
  string        t_name  [$];
  packet_type_e t_type  [$];
  int           t_dst_x [$];
  int           t_dst_y [$];
  int           t_src_x [$];
  int           t_src_y [$];
  int           t_tag   [$];
  int           t_len   [$];
  bit           t_inv   [$];

  // Input flits and the expected output flits, both in order.
  bit                     in_head  [$];
  bit                     in_tail  [$];
  logic [flit_data_w-1:0] in_data  [$];
  int                     in_test  [$];
  bit                     exp_head [$];
  bit                     exp_tail [$];
  logic [flit_data_w-1:0] exp_data [$];
  int                     exp_test [$];
  int                     exp_total [$];
  int                     remaining [$];
  int                     test_errs [$];

  logic [31:0] rng = 32'd57;
  int          err_count;
  int          failed_tests;
  int          cycles;
  int          cycle_limit;

  noc_error_checker #(
    .SIZE_X     (SIZE_X),
    .SIZE_Y     (SIZE_Y),
    .ERROR_DATA (ERROR_DATA)
  ) noc_error_checker_i (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_flit_valid (i_flit_valid),
    .i_flit_head  (i_flit_head),
    .i_flit_tail  (i_flit_tail),
    .i_flit_data  (i_flit_data),
    .o_flit_ready (o_flit_ready),
    .o_flit_valid (o_flit_valid),
    .o_flit_head  (o_flit_head),
    .o_flit_tail  (o_flit_tail),
    .o_flit_data  (o_flit_data),
    .i_flit_ready (i_flit_ready)
  );

  always #5 i_clk = ~i_clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [flit_data_w-1:0] pack_header(
    input packet_type_e ptype, input int dx, input int dy, input int sx, input int sy,
    input int tag, input int len, input bit inv, input status_e status);
    logic [flit_data_w-1:0] h;
    h = '0;
    h[type_lsb +: type_w]           = ptype;
    h[dst_x_lsb +: coord_w]         = dx[coord_w-1:0];
    h[dst_y_lsb +: coord_w]         = dy[coord_w-1:0];
    h[src_x_lsb +: coord_w]         = sx[coord_w-1:0];
    h[src_y_lsb +: coord_w]         = sy[coord_w-1:0];
    h[tag_lsb +: tag_w]             = tag[tag_w-1:0];
    h[burst_len_lsb +: burst_len_w] = len[burst_len_w-1:0];
    h[invalid_lsb]                  = inv;
    h[status_lsb +: status_w]       = status;
    return h;
  endfunction

  task automatic add_entry(input string name, input packet_type_e ptype,
                           input int dx, input int dy, input int sx, input int sy,
                           input int tag, input int len, input bit inv);
    t_name.push_back(name);
    t_type.push_back(ptype);
    t_dst_x.push_back(dx);
    t_dst_y.push_back(dy);
    t_src_x.push_back(sx);
    t_src_y.push_back(sy);
    t_tag.push_back(tag);
    t_len.push_back(len);
    t_inv.push_back(inv);
  endtask

  task automatic load_table();
    //        name                type                dx dy sx sy tag len inv
    add_entry("good_read",        READ,               1, 2, 0, 0, 1,  4,  0);
    add_entry("good_write",       WRITE,              3, 3, 1, 0, 2,  2,  0);
    add_entry("good_posted",      POSTED_WRITE,       0, 1, 2, 2, 3,  3,  0);
    add_entry("good_resp",        RESPONSE,           2, 0, 1, 1, 4,  0,  0);
    add_entry("good_resp_data",   RESPONSE_WITH_DATA, 3, 0, 0, 3, 5,  2,  0);
    add_entry("bad_read_x",       READ,               5, 1, 2, 3, 6,  3,  0);
    add_entry("bad_read_y",       READ,               2, 4, 1, 2, 7,  1,  0);
    add_entry("bad_write_inv",    WRITE,              1, 1, 3, 2, 8,  3,  1);
    add_entry("bad_posted",       POSTED_WRITE,       7, 0, 0, 1, 9,  2,  0);
    add_entry("good_write_after", WRITE,              2, 2, 3, 1, 10, 1,  0);
    add_entry("bad_read_long",    READ,               4, 4, 1, 3, 11, 5,  0);
    add_entry("good_read_after",  READ,               0, 3, 2, 1, 12, 2,  0);
    add_entry("bad_write_single", WRITE,              6, 2, 0, 2, 13, 0,  0);
    add_entry("good_write_last",  WRITE,              3, 1, 1, 2, 14, 4,  0);
  endtask

  task automatic add_expected(input int t, input bit head, input bit tail,
                              input logic [flit_data_w-1:0] data);
    exp_head.push_back(head);
    exp_tail.push_back(tail);
    exp_data.push_back(data);
    exp_test.push_back(t);
    exp_total[t] = exp_total[t] + 1;
  endtask

  // Reference model: good packets pass unchanged, bad requests get a decode error.
  task automatic build_packets();
    int                     t;
    int                     i;
    int                     n;
    int                     rlen;
    bit                     bad;
    packet_type_e           rtype;
    logic [flit_data_w-1:0] word;
    for (t = 0; t < t_name.size(); t++) begin
      n   = (t_type[t] == READ) ? 1 : t_len[t] + 1; // A read is header only.
      bad = t_inv[t] || (t_dst_x[t] >= SIZE_X) || (t_dst_y[t] >= SIZE_Y);
      exp_total.push_back(0);
      test_errs.push_back(0);
      for (i = 0; i < n; i++) begin
        if (i == 0) begin
          word = pack_header(t_type[t], t_dst_x[t], t_dst_y[t], t_src_x[t], t_src_y[t],
                             t_tag[t], t_len[t], t_inv[t], OKAY);
        end else begin
          rng  = xorshift32(rng);
          word = rng;
        end
        in_head.push_back(i == 0);
        in_tail.push_back(i == n - 1);
        in_data.push_back(word);
        in_test.push_back(t);
        if (!bad) add_expected(t, i == 0, i == n - 1, word);
      end
      if (bad && (t_type[t] == READ || t_type[t] == WRITE)) begin
        if (t_type[t] == READ) begin
          rtype = RESPONSE_WITH_DATA;
          rlen  = t_len[t];
        end else begin
          rtype = RESPONSE;
          rlen  = 0;
        end
        add_expected(t, 1'b1, rlen == 0,
                     pack_header(rtype, t_src_x[t], t_src_y[t], t_dst_x[t], t_dst_y[t],
                                 t_tag[t], rlen, 1'b0, DECODE_ERROR));
        for (i = 0; i < rlen; i++) add_expected(t, 1'b0, i == rlen - 1, ERROR_DATA);
      end
      remaining.push_back(exp_total[t]);
    end
  endtask

  task automatic report_test(input int t);
    if (test_errs[t] == 0) begin
      $display("test %0d %s ok", t, t_name[t]);
    end else begin
      $display("test %0d %s failed with %0d errors", t, t_name[t], test_errs[t]);
      failed_tests++;
    end
  endtask

  task automatic check_output_flit();
    int                     t;
    bit                     eh;
    bit                     et;
    logic [flit_data_w-1:0] ed;
    if (exp_data.size() == 0) begin
      $display("unexpected output flit with data %h after all expected flits", o_flit_data);
      err_count++;
    end else begin
      t  = exp_test.pop_front();
      eh = exp_head.pop_front();
      et = exp_tail.pop_front();
      ed = exp_data.pop_front();
      if (o_flit_head !== eh || o_flit_tail !== et || o_flit_data !== ed) begin
        $display("mismatch %s: expected head=%b tail=%b data=%h, actual head=%b tail=%b data=%h",
                 t_name[t], eh, et, ed, o_flit_head, o_flit_tail, o_flit_data);
        err_count++;
        test_errs[t]++;
      end
      remaining[t]--;
      if (remaining[t] == 0) report_test(t);
    end
  endtask

  // Output monitor.
  always @(posedge i_clk) begin
    if (i_rst_n && o_flit_valid && i_flit_ready) check_output_flit();
  end

  // Random output back-pressure, about one cycle in four.
  always @(posedge i_clk) begin
    if (i_rst_n) begin
      #1;
      rng          = xorshift32(rng);
      i_flit_ready = (rng[1:0] != 2'b00);
    end
  end

  always @(posedge i_clk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles with %0d output flits still missing",
               cycle_limit, exp_data.size());
      $display("TESTS FAILED");
      $finish;
    end
  end

  initial begin
    int f;
    i_clk        = 1'b0;
    i_rst_n      = 1'b0;
    i_flit_valid = 1'b0;
    i_flit_head  = 1'b0;
    i_flit_tail  = 1'b0;
    i_flit_data  = '0;
    i_flit_ready = 1'b1;
    err_count    = 0;
    failed_tests = 0;
    cycles       = 0;
    load_table();
    build_packets();
    cycle_limit = 20 * in_data.size() + 100;
    repeat (3) @(posedge i_clk);
    #1;
    i_rst_n = 1'b1;
    @(posedge i_clk);
    if (o_flit_valid !== 1'b0 || o_flit_ready !== 1'b1) begin
      $display("output not idle after reset: valid=%b ready=%b", o_flit_valid, o_flit_ready);
      err_count++;
    end else begin
      $display("reset state ok");
    end
    #1;
    for (f = 0; f < in_data.size(); f++) begin
      i_flit_valid = 1'b1;
      i_flit_head  = in_head[f];
      i_flit_tail  = in_tail[f];
      i_flit_data  = in_data[f];
      @(posedge i_clk);
      while (!o_flit_ready) @(posedge i_clk);
      #1;
      if (in_tail[f] && exp_total[in_test[f]] == 0) report_test(in_test[f]); // Dropped.
    end
    i_flit_valid = 1'b0;
    i_flit_head  = 1'b0;
    i_flit_tail  = 1'b0;
    while (exp_data.size() != 0) @(posedge i_clk);
    repeat (10) @(posedge i_clk); // Catch stray flits.
    $display("summary: %0d packets, %0d failed, %0d errors",
             t_name.size(), failed_tests, err_count);
    if (err_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: sim.f
noc_pkg.sv
noc_route_demux.sv
noc_error_responder.sv
noc_output_stage.sv
noc_error_checker.sv
noc_error_checker_chk.sv
tb_noc_error_checker.sv

// File: Makefile
.PHONY: compile run clean

compile:
	verilator --binary --assert --top-module tb_noc_error_checker -f sim.f -o sim_tb

run: compile
	@out="$$(./obj_dir/sim_tb)"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir
